/* prog_pkg.sv */
package prog_pkg;

  // RAM data word and its byte-lane enables
  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;

  // APB byte address as seen on the bus
  typedef logic [31:0] paddr_t;

  //////////////////////////////////////////////////////////////////////
  // Boot loader key
  //////////////////////////////////////////////////////////////////////

  // First received byte lands in the top byte
  localparam int BOOT_KEY_LEN = 8;
  localparam logic [BOOT_KEY_LEN*8-1:0] BOOT_KEY = "BOOTLOAD";

  // Loader sequence
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    KEY   = 3'd1,
    CHECK = 3'd2,
    COUNT = 3'd3,
    DATA  = 3'd4,
    DONE  = 3'd5
  } load_state_t;

endpackage

/* ram_wr_if.sv */
`timescale 1ns/10ps

interface ram_wr_if #(
  parameter int ADDR_W = 10
);

  // One word write, taken on the clock edge where en is high
  logic                en;
  logic [ADDR_W-1:0]   addr;
  prog_pkg::word_t     data;
  prog_pkg::strb_t     strb;

  modport src (
    output en,
    output addr,
    output data,
    output strb
  );

  modport sink (
    input en,
    input addr,
    input data,
    input strb
  );

endinterface

/* uart_rx.sv */
`timescale 1ns/10ps

module uart_rx #(
  parameter int CLKS_PER_BIT = 16
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       rx_i,
  output logic       rx_valid_o,
  output logic [7:0] rx_byte_o
);

  localparam int CW   = $clog2(CLKS_PER_BIT + 1);
  localparam int HALF = CLKS_PER_BIT / 2;

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_START = 2'd1;
  localparam logic [1:0] S_DATA  = 2'd2;
  localparam logic [1:0] S_STOP  = 2'd3;

  logic [1:0]    state_q;
  logic [CW-1:0] clk_cnt_q;
  logic [2:0]    bit_idx_q;
  logic          rx_meta_q;
  logic          rx_sync_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= S_IDLE;
      clk_cnt_q  <= '0;
      bit_idx_q  <= '0;
      rx_valid_o <= 1'b0;
      rx_meta_q  <= 1'b1;
      rx_sync_q  <= 1'b1;
    end else begin
      // Two flop synchroniser, line idles high
      rx_meta_q  <= rx_i;
      rx_sync_q  <= rx_meta_q;
      rx_valid_o <= 1'b0;
      case (state_q)
        S_IDLE: begin
          clk_cnt_q <= '0;
          bit_idx_q <= '0;
          if (!rx_sync_q) begin
            state_q <= S_START;
          end
        end
        S_START: begin
          // Recheck at mid start bit to reject glitches
          if (clk_cnt_q == CW'(HALF - 1)) begin
            clk_cnt_q <= '0;
            state_q   <= rx_sync_q ? S_IDLE : S_DATA;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        S_DATA: begin
          if (clk_cnt_q == CW'(CLKS_PER_BIT - 1)) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= S_STOP;
            end
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: begin
          // Stop bit, byte flagged only on a good frame
          if (clk_cnt_q == CW'(CLKS_PER_BIT - 1)) begin
            clk_cnt_q  <= '0;
            state_q    <= S_IDLE;
            rx_valid_o <= rx_sync_q;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  // LSB first shift at each mid-bit sample
  always_ff @(posedge clk_i) begin
    if (state_q == S_DATA && clk_cnt_q == CW'(CLKS_PER_BIT - 1)) begin
      rx_byte_o <= {rx_sync_q, rx_byte_o[7:1]};
    end
  end

endmodule

/* boot_loader.sv */
`timescale 1ns/10ps

module boot_loader #(
  parameter int RAM_DEPTH    = 1024,
  parameter int BREAK_CYCLES = 100000
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       rx_valid_i,
  input  logic [7:0] rx_byte_i,
  ram_wr_if.src      wr,
  output logic       load_busy_o,
  output logic       prog_mode_o,
  output logic       sys_rst_no
);

  localparam int AW  = $clog2(RAM_DEPTH);
  localparam int IW  = $clog2(BREAK_CYCLES + 1);
  localparam int KL  = prog_pkg::BOOT_KEY_LEN;
  localparam int KW  = KL * 8;
  localparam int KCW = $clog2(KL);

  prog_pkg::load_state_t state_q;

  logic [KW-1:0]   key_q;
  logic [KCW-1:0]  key_cnt_q;
  logic [IW-1:0]   idle_cnt_q;
  logic [1:0]      byte_cnt_q;
  logic [31:0]     count_q;
  logic [31:0]     count_next;
  prog_pkg::word_t word_q;
  logic [AW-1:0]   addr_q;
  logic [AW-1:0]   addr_next;
  logic            wr_en_q;

  assign count_next = {count_q[23:0], rx_byte_i};
  assign addr_next  = (addr_q == AW'(RAM_DEPTH - 1)) ? '0 : addr_q + 1'b1;

  //////////////////////////////////////////////////////////////////////
  // Sequence control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= prog_pkg::IDLE;
      key_cnt_q  <= '0;
      idle_cnt_q <= '0;
      byte_cnt_q <= '0;
      count_q    <= '0;
      addr_q     <= '0;
      wr_en_q    <= 1'b0;
    end else begin
      wr_en_q <= 1'b0;
      case (state_q)
        prog_pkg::IDLE: begin
          key_cnt_q  <= '0;
          idle_cnt_q <= '0;
          if (rx_valid_i) begin
            key_cnt_q <= KCW'(1);
            state_q   <= prog_pkg::KEY;
          end
        end
        prog_pkg::KEY: begin
          if (rx_valid_i) begin
            idle_cnt_q <= '0;
            if (key_cnt_q == KCW'(KL - 1)) begin
              key_cnt_q <= '0;
              state_q   <= prog_pkg::CHECK;
            end else begin
              key_cnt_q <= key_cnt_q + 1'b1;
            end
          end else if (idle_cnt_q == IW'(BREAK_CYCLES - 1)) begin
            // Line went quiet mid key, start over
            state_q <= prog_pkg::IDLE;
          end else begin
            idle_cnt_q <= idle_cnt_q + 1'b1;
          end
        end
        prog_pkg::CHECK: begin
          byte_cnt_q <= '0;
          state_q    <= (key_q == prog_pkg::BOOT_KEY) ? prog_pkg::COUNT : prog_pkg::IDLE;
        end
        prog_pkg::COUNT: begin
          if (rx_valid_i) begin
            count_q    <= count_next;
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (byte_cnt_q == 2'd3) begin
              addr_q  <= '0;
              state_q <= (count_next == '0) ? prog_pkg::DONE : prog_pkg::DATA;
            end
          end
        end
        prog_pkg::DATA: begin
          if (rx_valid_i) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
          end
          // Write goes out the cycle after the fourth byte
          wr_en_q <= rx_valid_i && (byte_cnt_q == 2'd3);
          if (wr_en_q) begin
            addr_q  <= addr_next;
            count_q <= count_q - 1'b1;
            if (count_q == 32'd1) begin
              state_q <= prog_pkg::DONE;
            end
          end
        end
        prog_pkg::DONE: begin
          state_q <= prog_pkg::IDLE;
        end
        default: begin
          state_q <= prog_pkg::IDLE;
        end
      endcase
    end
  end

  // Key and word assembly, MSB first
  always_ff @(posedge clk_i) begin
    if (rx_valid_i) begin
      if (state_q == prog_pkg::IDLE || state_q == prog_pkg::KEY) begin
        key_q <= {key_q[KW-9:0], rx_byte_i};
      end
      if (state_q == prog_pkg::DATA) begin
        word_q <= {word_q[23:0], rx_byte_i};
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  assign wr.en   = wr_en_q;
  assign wr.addr = addr_q;
  assign wr.data = word_q;
  assign wr.strb = 4'hF;

  assign load_busy_o = (state_q == prog_pkg::CHECK) || (state_q == prog_pkg::COUNT) ||
                       (state_q == prog_pkg::DATA) || (state_q == prog_pkg::DONE);
  assign prog_mode_o = (state_q == prog_pkg::DATA);
  // One cycle reset request once the image is in
  assign sys_rst_no  = (state_q != prog_pkg::DONE);

endmodule

/* byte_ram.sv */
`timescale 1ns/10ps

module byte_ram #(
  parameter int RAM_DEPTH = 1024
) (
  input  logic                         clk_i,
  ram_wr_if.sink                       ld,
  ram_wr_if.sink                       cpu,
  input  logic                         rd_en_i,
  input  logic [$clog2(RAM_DEPTH)-1:0] rd_addr_i,
  output prog_pkg::word_t              rd_data_o
);

  localparam int AW = $clog2(RAM_DEPTH);

  prog_pkg::word_t mem [RAM_DEPTH];

  logic            wr_en;
  logic [AW-1:0]   wr_addr;
  prog_pkg::word_t wr_data;
  prog_pkg::strb_t wr_strb;

  // Loader wins if both sides write at once
  always_comb begin
    wr_en = ld.en | cpu.en;
    if (ld.en) begin
      wr_addr = ld.addr;
      wr_data = ld.data;
      wr_strb = ld.strb;
    end else begin
      wr_addr = cpu.addr;
      wr_data = cpu.data;
      wr_strb = cpu.strb;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int i = 0; i < 4; i++) begin
        if (wr_strb[i]) begin
          mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

  // Registered read, data one cycle after rd_en
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_addr_i];
    end
  end

endmodule

/* apb_ram_port.sv */
`timescale 1ns/10ps

module apb_ram_port #(
  parameter int RAM_DEPTH = 1024
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  prog_pkg::paddr_t             paddr_i,
  input  prog_pkg::word_t              pwdata_i,
  input  prog_pkg::strb_t              pstrb_i,
  output prog_pkg::word_t              prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  input  logic                         load_busy_i,
  ram_wr_if.src                        wr,
  output logic                         rd_en_o,
  output logic [$clog2(RAM_DEPTH)-1:0] rd_addr_o,
  input  prog_pkg::word_t              rd_data_i
);

  localparam int AW = $clog2(RAM_DEPTH);

  logic access;
  logic in_range;
  logic rd_pend_q;

  // Access phase that is allowed to proceed
  assign access   = psel_i && penable_i && !load_busy_i;
  assign in_range = (paddr_i < prog_pkg::paddr_t'(RAM_DEPTH * 4));

  // Reads need one wait state for the RAM
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rd_pend_q <= 1'b0;
    end else if (pready_o) begin
      rd_pend_q <= 1'b0;
    end else if (rd_en_o) begin
      rd_pend_q <= 1'b1;
    end
  end

  assign rd_en_o   = access && !pwrite_i && in_range && !rd_pend_q;
  assign rd_addr_o = paddr_i[AW+1:2];

  assign wr.en   = access && pwrite_i && in_range;
  assign wr.addr = paddr_i[AW+1:2];
  assign wr.data = pwdata_i;
  assign wr.strb = pstrb_i;

  assign pready_o  = access && (pwrite_i || rd_pend_q || !in_range);
  assign pslverr_o = pready_o && !in_range;
  assign prdata_o  = rd_pend_q ? rd_data_i : '0;

endmodule

/* prog_ram_top.sv */
`timescale 1ns/10ps

module prog_ram_top #(
  parameter int CLKS_PER_BIT = 16,
  parameter int RAM_DEPTH    = 1024,
  parameter int BREAK_CYCLES = 100000
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             psel_i,
  input  logic             penable_i,
  input  logic             pwrite_i,
  input  prog_pkg::paddr_t paddr_i,
  input  prog_pkg::word_t  pwdata_i,
  input  prog_pkg::strb_t  pstrb_i,
  output prog_pkg::word_t  prdata_o,
  output logic             pready_o,
  output logic             pslverr_o,
  input  logic             uart_rx_i,
  output logic             sys_rst_no,
  output logic             prog_mode_o
);

  localparam int AW = $clog2(RAM_DEPTH);

  logic            rx_valid;
  logic [7:0]      rx_byte;
  logic            load_busy;
  logic            rd_en;
  logic [AW-1:0]   rd_addr;
  prog_pkg::word_t rd_data;

  // Write channels into the RAM
  ram_wr_if #(.ADDR_W(AW)) ld_wr ();
  ram_wr_if #(.ADDR_W(AW)) cpu_wr ();

  //////////////////////////////////////////////////////////////////////
  // Serial boot path
  //////////////////////////////////////////////////////////////////////

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_rx (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rx_i       (uart_rx_i),
    .rx_valid_o (rx_valid),
    .rx_byte_o  (rx_byte)
  );

  boot_loader #(
    .RAM_DEPTH    (RAM_DEPTH),
    .BREAK_CYCLES (BREAK_CYCLES)
  ) u_loader (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rx_valid_i  (rx_valid),
    .rx_byte_i   (rx_byte),
    .wr          (ld_wr.src),
    .load_busy_o (load_busy),
    .prog_mode_o (prog_mode_o),
    .sys_rst_no  (sys_rst_no)
  );

  //////////////////////////////////////////////////////////////////////
  // Memory and processor port
  //////////////////////////////////////////////////////////////////////

  byte_ram #(
    .RAM_DEPTH (RAM_DEPTH)
  ) u_ram (
    .clk_i     (clk_i),
    .ld        (ld_wr.sink),
    .cpu       (cpu_wr.sink),
    .rd_en_i   (rd_en),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  apb_ram_port #(
    .RAM_DEPTH (RAM_DEPTH)
  ) u_apb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .pstrb_i     (pstrb_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .load_busy_i (load_busy),
    .wr          (cpu_wr.src),
    .rd_en_o     (rd_en),
    .rd_addr_o   (rd_addr),
    .rd_data_i   (rd_data)
  );

endmodule

/* prog_ram_chk.sv */
`timescale 1ns/10ps

module prog_ram_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic psel_i,
  input logic penable_i,
  input logic pready_i,
  input logic sys_rst_ni,
  input logic cpu_wr_en_i,
  input logic load_busy_i,
  input logic prog_mode_i
);

  // pready only inside an access phase
  a_pready_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pready_i |-> (psel_i && penable_i))
    else $error("pready high outside an APB access phase");

  a_rst_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !sys_rst_ni |=> sys_rst_ni)
    else $error("sys_rst_no low for more than one cycle");

  // CPU side must stall while the loader owns the RAM
  a_no_cpu_wr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(cpu_wr_en_i && load_busy_i))
    else $error("APB write enable high during a load");

  a_prog_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    prog_mode_i |-> load_busy_i)
    else $error("prog_mode_o high without load_busy");

endmodule

bind prog_ram_top prog_ram_chk u_chk (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .psel_i      (psel_i),
  .penable_i   (penable_i),
  .pready_i    (pready_o),
  .sys_rst_ni  (sys_rst_no),
  .cpu_wr_en_i (cpu_wr.en),
  .load_busy_i (load_busy),
  .prog_mode_i (prog_mode_o)
);

/* tb_prog_ram.sv */
`timescale 1ns/10ps

module tb_prog_ram;

  localparam int CLKS_PER_BIT = 8;
  localparam int RAM_DEPTH    = 64;
  localparam int BREAK_CYCLES = 400;

  logic             clk;
  logic             rst_n;
  logic             psel;
  logic             penable;
  logic             pwrite;
  prog_pkg::paddr_t paddr;
  prog_pkg::word_t  pwdata;
  prog_pkg::strb_t  pstrb;
  prog_pkg::word_t  prdata;
  logic             pready;
  logic             pslverr;
  logic             uart_rx;
  logic             sys_rst_n;
  logic             prog_mode;

  // Bytes queued for the serial line, and the words they were cut from
  logic [7:0]      tx_q[$];
  prog_pkg::word_t sent_words[$];
  // Reference memory by word index
  prog_pkg::word_t model[int];
  logic [31:0]     rnd_state;
  int              rst_pulses = 0;
  int              pulse_base = 0;
  logic            run_closed = 1'b0;

  prog_ram_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT),
    .RAM_DEPTH    (RAM_DEPTH),
    .BREAK_CYCLES (BREAK_CYCLES)
  ) u_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .psel_i      (psel),
    .penable_i   (penable),
    .pwrite_i    (pwrite),
    .paddr_i     (paddr),
    .pwdata_i    (pwdata),
    .pstrb_i     (pstrb),
    .prdata_o    (prdata),
    .pready_o    (pready),
    .pslverr_o   (pslverr),
    .uart_rx_i   (uart_rx),
    .sys_rst_no  (sys_rst_n),
    .prog_mode_o (prog_mode)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Count clocks with the reset request low
  always @(posedge clk) begin
    if (rst_n && !sys_rst_n) begin
      rst_pulses <= rst_pulses + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Error handling and compares
  ////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    run_closed = 1'b1;
    $display("Simulation FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out waiting for %s", what);
    abort_run();
  endtask

  task automatic check_word(input string name, input prog_pkg::word_t got,
                            input prog_pkg::word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_resp(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // Bus and line drivers
  ////////////////////////////////////////////////////////////////////////

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #2;
    end
  endtask

  // Entered and left 2 ns after a rising edge
  task automatic apb_xfer(input logic wr, input prog_pkg::paddr_t addr,
                          input prog_pkg::word_t data, input prog_pkg::strb_t strb,
                          input int limit, output prog_pkg::word_t rd, output logic err);
    int n;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    pstrb   = strb;
    @(posedge clk);
    #2;
    penable = 1'b1;
    n = 0;
    @(negedge clk);
    while (!pready) begin
      if (n == limit) begin
        report_timeout("pready_o");
      end
      n++;
      @(negedge clk);
    end
    rd  = prdata;
    err = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic drive_bit(input logic v);
    uart_rx = v;
    idle(CLKS_PER_BIT);
  endtask

  // 8N1 frames, LSB first
  task automatic send_bytes();
    logic [7:0] b;
    int         i;
    while (tx_q.size() > 0) begin
      b = tx_q.pop_front();
      drive_bit(1'b0);
      for (i = 0; i < 8; i++) begin
        drive_bit(b[i]);
      end
      drive_bit(1'b1);
    end
  endtask

  task automatic queue_word(input prog_pkg::word_t w);
    tx_q.push_back(w[31:24]);
    tx_q.push_back(w[23:16]);
    tx_q.push_back(w[15:8]);
    tx_q.push_back(w[7:0]);
    sent_words.push_back(w);
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Commands
  ////////////////////////////////////////////////////////////////////////

  // Last full key in the sent stream, then count, then the data words
  task automatic commit_load();
    int k;
    int cnt;
    int i;
    k = -1;
    for (i = 0; i + 1 < sent_words.size(); i++) begin
      if (sent_words[i] == prog_pkg::BOOT_KEY[63:32] &&
          sent_words[i+1] == prog_pkg::BOOT_KEY[31:0]) begin
        k = i;
      end
    end
    if (k >= 0 && k + 2 < sent_words.size()) begin
      cnt = int'(sent_words[k+2]);
      for (i = 0; i < cnt && k + 3 + i < sent_words.size(); i++) begin
        model[i % RAM_DEPTH] = sent_words[k+3+i];
      end
    end
    sent_words.delete();
  endtask

  task automatic apb_write(input prog_pkg::paddr_t addr, input prog_pkg::word_t data,
                           input prog_pkg::strb_t strb);
    prog_pkg::word_t mask;
    prog_pkg::word_t old;
    prog_pkg::word_t rd;
    logic            err;
    int              i;
    for (i = 0; i < 4; i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    // Disabled lanes carry filler that must not reach the RAM
    rnd_state = xorshift(rnd_state);
    apb_xfer(1'b1, addr, (data & mask) | (rnd_state & ~mask), strb, 4, rd, err);
    check_resp("pslverr_o", err, 1'b0);
    old = model.exists(int'(addr >> 2)) ? model[int'(addr >> 2)] : 'x;
    model[int'(addr >> 2)] = (old & ~mask) | (data & mask);
  endtask

  task automatic read_check(input prog_pkg::paddr_t addr, input prog_pkg::word_t exp);
    prog_pkg::word_t rd;
    logic            err;
    apb_xfer(1'b0, addr, '0, '0, 4, rd, err);
    check_resp("pslverr_o", err, 1'b0);
    check_word("prdata_o", rd, exp);
    if (!model.exists(int'(addr >> 2)) || model[int'(addr >> 2)] !== exp) begin
      $display("Expected word 0x%08h at 0x%08h disagrees with the reference model",
               exp, addr);
      abort_run();
    end
  endtask

  task automatic range_check(input prog_pkg::paddr_t addr, input logic wr);
    prog_pkg::word_t rd;
    logic            err;
    int              idx;
    rnd_state = xorshift(rnd_state);
    apb_xfer(wr, addr, rnd_state, 4'hF, 4, rd, err);
    check_resp("pslverr_o", err, 1'b1);
    // A rejected write must leave the word it would alias to alone
    idx = int'(addr >> 2) % RAM_DEPTH;
    if (wr && model.exists(idx)) begin
      apb_xfer(1'b0, prog_pkg::paddr_t'(idx * 4), '0, '0, 4, rd, err);
      check_resp("pslverr_o", err, 1'b0);
      check_word("prdata_o", rd, model[idx]);
    end
  endtask

  // Issued once the loader is in DATA, so it must stall to the end
  task automatic stalled_read(input prog_pkg::paddr_t addr, input prog_pkg::word_t exp);
    prog_pkg::word_t rd;
    logic            err;
    int              n;
    n = 0;
    @(negedge clk);
    while (!prog_mode) begin
      if (n == 4000) begin
        report_timeout("prog_mode_o");
      end
      n++;
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    apb_xfer(1'b0, addr, '0, '0, 4000, rd, err);
    if (rst_pulses - pulse_base != 1) begin
      $display("APB read completed before the load had finished");
      abort_run();
    end
    check_bit("prog_mode_o", prog_mode, 1'b0);
    check_resp("pslverr_o", err, 1'b0);
    check_word("prdata_o", rd, exp);
  endtask

  task automatic expect_pulse();
    int n;
    n = 0;
    while (rst_pulses == pulse_base) begin
      if (n == 4000) begin
        report_timeout("the sys_rst_no pulse");
      end
      n++;
      idle(1);
    end
    idle(4);
    if (rst_pulses - pulse_base != 1) begin
      $display("Expected one reset pulse but saw %0d", rst_pulses - pulse_base);
      abort_run();
    end
    pulse_base = rst_pulses;
    commit_load();
  endtask

  task automatic expect_no_pulse(input int cycles);
    idle(cycles);
    if (rst_pulses != pulse_base) begin
      $display("Unexpected reset pulse after a rejected load");
      abort_run();
    end
    sent_words.delete();
  endtask

  initial begin
    int               fd;
    int               code;
    logic [7:0]       cmd;
    logic [31:0]      a0;
    logic [31:0]      a1;
    logic [31:0]      a2;
    logic [8*128-1:0] line;
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    pstrb     = '0;
    uart_rx   = 1'b1;
    rnd_state = 32'd38;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    fd = $fopen("prog_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Cannot open prog_stimulus.txt");
      abort_run();
    end
    code = $fscanf(fd, " %c", cmd);
    while (code == 1) begin
      case (cmd)
        "#": code = $fgets(line, fd);
        "A": begin
          code = $fscanf(fd, "%h %h %h", a0, a1, a2);
          apb_write(a0, a1, a2[3:0]);
        end
        "R": begin
          code = $fscanf(fd, "%h %h", a0, a1);
          read_check(a0, a1);
        end
        "E": begin
          code = $fscanf(fd, "%h %h", a0, a1);
          range_check(a0, a1[0]);
        end
        "U": begin
          code = $fscanf(fd, "%h", a0);
          queue_word(a0);
        end
        "T": send_bytes();
        "S": begin
          code = $fscanf(fd, "%h %h", a0, a1);
          fork
            send_bytes();
            stalled_read(a0, a1);
          join
        end
        "I": begin
          code = $fscanf(fd, "%h", a0);
          idle(int'(a0));
        end
        "P": expect_pulse();
        "N": begin
          code = $fscanf(fd, "%h", a0);
          expect_no_pulse(int'(a0));
        end
        default: begin
          $display("Unknown command in the stimulus file");
          abort_run();
        end
      endcase
      code = $fscanf(fd, " %c", cmd);
    end
    $fclose(fd);
    run_closed = 1'b1;
    $display("Simulation PASSED");
    $finish;
  end

  // An assertion stop ends the run without the normal ending
  final begin
    if (!run_closed) begin
      $display("Simulation FAILED");
    end
  end

endmodule

/* prog_stimulus.txt */
# A addr data strb | R addr expected | E addr write (pslverr expected) | I cycles
# U word (4 UART bytes, MSB first) | T send | S addr expected | P pulse | N cycles
A 10 11223344 F
A 10 00BB00DD 5
R 10 11BB33DD
A 0 DEADBEEF F
A 4 01020304 F
# Wrong key leaves memory alone
U 424F4F54
U 4C4F4158
U 00000001
U 55555555
T
N 258
R 0 DEADBEEF
R 4 01020304
# Good load of three words
U 424F4F54
U 4C4F4144
U 00000003
U 12345678
U 9ABCDEF0
U 0F1E2D3C
T
P
R 0 12345678
R 4 9ABCDEF0
R 8 0F1E2D3C
# Partial key dropped after a break
U 424F4F54
T
I 258
U 424F4F54
U 4C4F4144
U 00000002
U A5A5A5A5
U 3C3C3C3C
T
P
R 0 A5A5A5A5
R 4 3C3C3C3C
R 8 0F1E2D3C
R 10 11BB33DD
# Read stalls during a load
U 424F4F54
U 4C4F4144
U 00000002
U 0BADF00D
U 600DCAFE
S 4 600DCAFE
P
R 0 0BADF00D
E 100 0
E 104 1

/* verilog.f */
prog_pkg.sv
ram_wr_if.sv
uart_rx.sv
boot_loader.sv
byte_ram.sv
apb_ram_port.sv
prog_ram_top.sv
prog_ram_chk.sv
tb_prog_ram.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the failure line in the log
verilator --binary --timing --assert --top-module tb_prog_ram -f verilog.f -o sim_prog_ram \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_prog_ram > sim.log 2>&1 || echo "Simulation FAILED" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0
